/* source/lsu_addr_gen.sv */
// Memory address register of the vector LSU.
// Unit stride, constant stride (rs2_data) and indexed-ordered modes.
// Indices are zero extended and read at the element width.
// rs1_data, rs2_data, sew and vs2_data must hold for the whole instruction.
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               start,       // Load element 0 address
    input  logic               step,        // Advance to the next element
    input  lsu_pkg::elem_idx_t elem_idx,    // Element now on the bus
    input  lsu_pkg::addr_t     rs1_data,    // Base
    input  lsu_pkg::addr_t     rs2_data,    // Constant stride in bytes
    input  logic               stride_sel,  // 1 selects unit stride
    input  logic               index_str,   // Indexed mode
    input  lsu_pkg::sew_t      sew,
    input  lsu_pkg::vreg_t     vs2_data,    // Index vector
    output lsu_pkg::addr_t     lsu2mem_addr
);
    import lsu_pkg::*;

    elem_idx_t next_idx;                    // Element whose address is loaded next
    addr_t     elem_bytes;
    addr_t     stride;
    addr_t     index_val;

    // Element 0 on start, else the one after the current beat
    assign next_idx = start ? '0 : elem_idx + 1'b1;

    // Element size in bytes
    always_comb begin
        case (sew)
            SEW_8:   elem_bytes = addr_t'(1);
            SEW_16:  elem_bytes = addr_t'(2);
            SEW_32:  elem_bytes = addr_t'(4);
            default: elem_bytes = '0;       // Reserved code, address stalls
        endcase
    end

    assign stride = stride_sel ? elem_bytes : rs2_data;

    // Index of next_idx; low index bits only, so the select stays inside vs2_data
    always_comb begin
        case (sew)
            SEW_8:   index_val = addr_t'(vs2_data[{next_idx, 3'b000} +: 8]);
            SEW_16:  index_val = addr_t'(vs2_data[{next_idx[2:0], 4'b0000} +: 16]);
            SEW_32:  index_val = addr_t'(vs2_data[{next_idx[1:0], 5'b00000} +: 32]);
            default: index_val = '0;
        endcase
    end

    // One cycle from start or step to the new address
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            lsu2mem_addr <= '0;
        end else if (start || step) begin
            if (index_str) begin
                lsu2mem_addr <= rs1_data + index_val;   // Base plus index k
            end else if (start) begin
                lsu2mem_addr <= rs1_data;               // Element 0 at base
            end else begin
                lsu2mem_addr <= lsu2mem_addr + stride;  // Running sum
            end
        end
    end

endmodule : lsu_addr_gen

`default_nettype wire

/* source/lsu_ctrl.sv */
// Sequencer of the vector LSU, one element per beat.
// Strobes are only seen in IDLE; ld_inst wins over st_inst.
// vl must be stable and nonzero from the strobe to the done pulse.
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               ld_inst,     // Load strobe
    input  logic               st_inst,     // Store strobe
    input  lsu_pkg::vl_t       vl,          // Elements to move
    output logic               start,       // Accepting cycle
    output logic               step,        // A beat is issued this cycle
    output logic               is_ld,       // Current or accepted op is a load
    output lsu_pkg::elem_idx_t elem_idx,    // Element of the current beat
    output logic               ld_req,
    output logic               st_req,
    output logic               is_loaded,   // One cycle after the last load beat
    output logic               is_stored    // One cycle after the last store beat
);
    import lsu_pkg::*;

    lsu_state_e state_q;
    lsu_state_e state_d;
    logic       last_elem;                  // Beat of element vl-1

    // Request levels come straight from the state
    assign ld_req = (state_q == LOAD);
    assign st_req = (state_q == STORE);
    assign step   = ld_req || st_req;

    // Accept only when idle
    assign start  = (state_q == IDLE) && (ld_inst || st_inst);

    // In IDLE the strobe decides, later the state
    assign is_ld  = (state_q == IDLE) ? ld_inst : ld_req;

    // Compared at count width so vl of 16 works
    assign last_elem = (vl_t'(elem_idx) + vl_t'(1)) == vl;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ld_inst) begin
                    state_d = LOAD;
                end else if (st_inst) begin
                    state_d = STORE;
                end
            end
            LOAD, STORE: begin
                if (last_elem) begin
                    state_d = IDLE;         // Back in IDLE with the done pulse
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Element counter, restarts on every accepted strobe
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            elem_idx <= '0;
        end else if (start) begin
            elem_idx <= '0;
        end else if (step) begin
            if (last_elem) begin
                elem_idx <= '0;             // Park at zero
            end else begin
                elem_idx <= elem_idx + 1'b1;
            end
        end
    end

    // Done pulses land in cycle vl+1
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            is_loaded <= 1'b0;
            is_stored <= 1'b0;
        end else begin
            is_loaded <= ld_req && last_elem;
            is_stored <= st_req && last_elem;
        end
    end

endmodule : lsu_ctrl

`default_nettype wire

/* source/lsu_elem_data.sv */
// Element data path of the vector LSU.
// Loads take the low sew bits of the memory word into slot elem_idx.
// The image is cleared when a load starts; it holds until the next load.
// Store data and strobe are combinational from elem_idx and sew.
`timescale 1ns/1ps
`default_nettype none

module lsu_elem_data (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               start,        // Accepting cycle
    input  logic               step,         // Beat this cycle
    input  logic               is_ld,        // Beat or start belongs to a load
    input  lsu_pkg::elem_idx_t elem_idx,
    input  lsu_pkg::sew_t      sew,
    input  lsu_pkg::bus_t      mem2lsu_data, // Valid in the ld_req cycle
    input  lsu_pkg::vreg_t     vs3_data,     // Store source register
    output lsu_pkg::vreg_t     vd_data,      // Gathered load image
    output lsu_pkg::bus_t      lsu2mem_data,
    output lsu_pkg::strb_t     wr_strobe
);
    import lsu_pkg::*;

    logic ld_beat;                           // Capture this edge

    assign ld_beat = step && is_ld;

    // Gather buffer, one slot written per load beat
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vd_data <= '0;
        end else if (start && is_ld) begin
            vd_data <= '0;                   // Slots at or above vl read zero
        end else if (ld_beat) begin
            case (sew)
                SEW_8: begin
                    vd_data[{elem_idx, 3'b000} +: 8] <= mem2lsu_data[7:0];
                end
                SEW_16: begin
                    vd_data[{elem_idx[2:0], 4'b0000} +: 16] <= mem2lsu_data[15:0];
                end
                SEW_32: begin
                    vd_data[{elem_idx[1:0], 5'b00000} +: 32] <= mem2lsu_data[31:0];
                end
                default: begin
                    vd_data <= vd_data;      // Reserved width writes nothing
                end
            endcase
        end
    end

    // Store element in the low lanes, upper lanes zero
    always_comb begin
        lsu2mem_data = '0;
        wr_strobe    = '0;
        case (sew)
            SEW_8: begin
                lsu2mem_data = bus_t'(vs3_data[{elem_idx, 3'b000} +: 8]);
                wr_strobe    = strb_t'(4'b0001);    // One byte
            end
            SEW_16: begin
                lsu2mem_data = bus_t'(vs3_data[{elem_idx[2:0], 4'b0000} +: 16]);
                wr_strobe    = strb_t'(4'b0011);    // Two bytes
            end
            SEW_32: begin
                lsu2mem_data = bus_t'(vs3_data[{elem_idx[1:0], 5'b00000} +: 32]);
                wr_strobe    = '1;                  // Full word
            end
            default: begin
                lsu2mem_data = '0;                  // Reserved code, no write
                wr_strobe    = '0;
            end
        endcase
    end

endmodule : lsu_elem_data

`default_nettype wire

/* source/lsu_pkg.sv */
// Widths, types and encodings shared by every block of the vector LSU.
// Only 8, 16 and 32 bit elements exist; the code 2'b11 is reserved.
// vl must stay within VLEN_BITS divided by the element width.
`default_nettype none

package lsu_pkg;

    // Scalar side
    localparam int XLEN      = 32;           // Address and stride width
    localparam int VLEN_BITS = 128;          // One vector register

    // Memory side
    localparam int DATA_BUS  = 32;           // One element per beat
    localparam int STRB_W    = DATA_BUS / 8; // Byte lanes

    // Longest vector, reached at 8 bit elements
    localparam int MAX_ELEMS = VLEN_BITS / 8;

    typedef logic [XLEN-1:0]      addr_t;    // Address or stride
    typedef logic [VLEN_BITS-1:0] vreg_t;    // Vector register image
    typedef logic [DATA_BUS-1:0]  bus_t;     // Memory word
    typedef logic [STRB_W-1:0]    strb_t;    // Byte write enables

    // Count needs one more bit than the index to hold MAX_ELEMS itself
    typedef logic [$clog2(MAX_ELEMS+1)-1:0] vl_t;
    typedef logic [$clog2(MAX_ELEMS)-1:0]   elem_idx_t;

    // Element width codes
    typedef logic [1:0] sew_t;
    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;

    // Controller states, one instruction at a time
    typedef enum logic [1:0] {
        IDLE,                                // Waiting for a strobe
        LOAD,                                // ld_req beats
        STORE                                // st_req beats
    } lsu_state_e;

endpackage : lsu_pkg

`default_nettype wire

/* source/vec_lsu.sv */
// Top of the vector load/store unit, one instruction and one element per beat.
// Memory must return load data in the same cycle as ld_req; no back-pressure.
// Instruction inputs must hold from the strobe until is_loaded or is_stored.
// vl runs from 1 to VLEN_BITS divided by the element width.
`timescale 1ns/1ps
`default_nettype none

module vec_lsu (
    input  logic               clk,
    input  logic               n_rst,

    // Instruction side
    input  logic               ld_inst,      // Single cycle strobes
    input  logic               st_inst,
    input  lsu_pkg::addr_t     rs1_data,     // Base address
    input  lsu_pkg::addr_t     rs2_data,     // Constant stride
    input  logic               stride_sel,   // Unit stride over constant stride
    input  logic               index_str,    // Indexed-ordered mode
    input  lsu_pkg::sew_t      sew,
    input  lsu_pkg::vl_t       vl,
    input  lsu_pkg::vreg_t     vs2_data,     // Indices
    input  lsu_pkg::vreg_t     vs3_data,     // Store data

    // Memory side
    input  lsu_pkg::bus_t      mem2lsu_data,
    output lsu_pkg::addr_t     lsu2mem_addr,
    output logic               ld_req,
    output logic               st_req,
    output lsu_pkg::bus_t      lsu2mem_data,
    output lsu_pkg::strb_t     wr_strobe,

    // Register file side
    output lsu_pkg::vreg_t     vd_data,
    output logic               is_loaded,
    output logic               is_stored
);
    import lsu_pkg::*;

    logic      start;
    logic      step;
    logic      is_ld;
    elem_idx_t elem_idx;

    // Sequencing and handshake levels
    lsu_ctrl u_ctrl (
        .clk       (clk),
        .n_rst     (n_rst),
        .ld_inst   (ld_inst),
        .st_inst   (st_inst),
        .vl        (vl),
        .start     (start),
        .step      (step),
        .is_ld     (is_ld),
        .elem_idx  (elem_idx),
        .ld_req    (ld_req),
        .st_req    (st_req),
        .is_loaded (is_loaded),
        .is_stored (is_stored)
    );

    // Address, one cycle behind start and step
    lsu_addr_gen u_addr_gen (
        .clk          (clk),
        .n_rst        (n_rst),
        .start        (start),
        .step         (step),
        .elem_idx     (elem_idx),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .stride_sel   (stride_sel),
        .index_str    (index_str),
        .sew          (sew),
        .vs2_data     (vs2_data),
        .lsu2mem_addr (lsu2mem_addr)
    );

    // Load gather and store element select
    lsu_elem_data u_elem_data (
        .clk          (clk),
        .n_rst        (n_rst),
        .start        (start),
        .step         (step),
        .is_ld        (is_ld),
        .elem_idx     (elem_idx),
        .sew          (sew),
        .mem2lsu_data (mem2lsu_data),
        .vs3_data     (vs3_data),
        .vd_data      (vd_data),
        .lsu2mem_data (lsu2mem_data),
        .wr_strobe    (wr_strobe)
    );

endmodule : vec_lsu

`default_nettype wire

/* tb.f */
source/lsu_pkg.sv
source/lsu_ctrl.sv
source/lsu_addr_gen.sv
source/lsu_elem_data.sv
source/vec_lsu.sv
testbench/tb_clk_gen.sv
testbench/vec_lsu_chk.sv
testbench/vec_lsu_tb.sv

/* testbench/tb_clk_gen.sv */
// Free running clock, 20 ns period.
// n_rst is held low for 8 cycles and released on a falling edge.
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic n_rst
);
    initial begin
        clk   = 1'b0;
        n_rst = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;                       // Away from the sampling edge
    end

    always #10 clk = ~clk;

endmodule : tb_clk_gen

`default_nettype wire

/* testbench/vec_lsu_chk.sv */
// Protocol assertions for vec_lsu, attached with bind.
// err_count is read by the testbench to stop the run.
`timescale 1ns/1ps
`default_nettype none

module vec_lsu_chk (
    input logic               clk,
    input logic               n_rst,
    input logic               ld_req,
    input logic               st_req,
    input logic               is_loaded,
    input logic               is_stored,
    input lsu_pkg::strb_t     wr_strobe
);
    int err_count = 0;                      // Failed assertions so far

    // One request kind at a time
    req_exclusive: assert property (@(posedge clk) disable iff (!n_rst)
        !(ld_req && st_req))
    else begin
        $error("ld_req and st_req high together");
        err_count++;
    end

    // Everything quiet while in reset
    quiet_in_reset: assert property (@(posedge clk)
        !n_rst |-> !(ld_req || st_req || is_loaded || is_stored))
    else begin
        $error("request or done high during reset");
        err_count++;
    end

    // Done pulses only right after the request drops
    loaded_after_req: assert property (@(posedge clk) disable iff (!n_rst)
        is_loaded |-> $fell(ld_req))
    else begin
        $error("is_loaded without a falling ld_req");
        err_count++;
    end

    stored_after_req: assert property (@(posedge clk) disable iff (!n_rst)
        is_stored |-> $fell(st_req))
    else begin
        $error("is_stored without a falling st_req");
        err_count++;
    end

    // A store beat always writes something
    strobe_on_store: assert property (@(posedge clk) disable iff (!n_rst)
        st_req |-> (wr_strobe != '0))
    else begin
        $error("wr_strobe zero during st_req");
        err_count++;
    end

endmodule : vec_lsu_chk

`default_nettype wire

/* testbench/vec_lsu_tb.sv */
// Testbench for vec_lsu with a 256 byte memory, addresses wrap on 8 bits.
// Memory answers ld_req in the same cycle; stores land on the st_req edge.
// Checking is done by assertions here and in the bound checker.
`timescale 1ns/1ps
`default_nettype none

module vec_lsu_tb;
    import lsu_pkg::*;

    localparam int NUM_INSTR    = 8;
    localparam int SUM_VL       = 47;       // Sum of vl over the tests below
    localparam int WATCH_CYCLES = SUM_VL + NUM_INSTR * 5 + 8 + 50;

    logic clk, n_rst;
    logic ld_inst, st_inst, stride_sel, index_str;
    addr_t rs1_data, rs2_data, lsu2mem_addr;
    sew_t sew;
    vl_t vl;
    vreg_t vs2_data, vs3_data, vd_data;
    bus_t mem2lsu_data, lsu2mem_data;
    strb_t wr_strobe;
    logic ld_req, st_req, is_loaded, is_stored;

    logic [7:0] mem [0:255];                // DUT side memory
    logic [7:0] ref_mem [0:255];            // Expected contents
    logic [31:0] rng = 32'd43;
    vreg_t exp_vd;
    addr_t exp_addr;
    strb_t exp_strb;                        // sew/8 low lanes
    int beat_k;                             // Beats of the current request
    logic [7:0] a0;

    tb_clk_gen u_clk_gen (.clk(clk), .n_rst(n_rst));

    vec_lsu UUT (.*);

    bind vec_lsu vec_lsu_chk u_chk (
        .clk(clk), .n_rst(n_rst), .ld_req(ld_req), .st_req(st_req),
        .is_loaded(is_loaded), .is_stored(is_stored), .wr_strobe(wr_strobe)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int sew_bytes(input sew_t w);
        return (w == SEW_8) ? 1 : (w == SEW_16) ? 2 : 4;
    endfunction

    // Address of element k by the addressing rules
    function automatic addr_t elem_addr(input int k, input addr_t base, input addr_t strd,
                                        input logic unit, input logic idx, input sew_t w,
                                        input vreg_t v2);
        addr_t ix;
        if (idx) begin
            case (w)
                SEW_8:   ix = addr_t'(v2[k*8 +: 8]);
                SEW_16:  ix = addr_t'(v2[k*16 +: 16]);
                default: ix = addr_t'(v2[k*32 +: 32]);
            endcase
            return base + ix;
        end
        return base + addr_t'(k) * (unit ? addr_t'(sew_bytes(w)) : strd);
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Combinational load answer, little endian
    assign a0 = lsu2mem_addr[7:0];
    assign mem2lsu_data = ld_req ? {mem[8'(a0 + 3)], mem[8'(a0 + 2)],
                                    mem[8'(a0 + 1)], mem[a0]} : '0;

    always @(posedge clk) begin
        if (st_req) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strobe[b]) mem[8'(a0 + b)] <= lsu2mem_data[b*8 +: 8];
            end
        end
    end

    // Beat counter, zero on the first request cycle
    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) beat_k <= 0;
        else if (ld_req || st_req) beat_k <= beat_k + 1;
        else beat_k <= 0;
    end

    always_comb exp_addr = elem_addr(beat_k, rs1_data, rs2_data, stride_sel, index_str,
                                     sew, vs2_data);

    always_comb exp_strb = strb_t'((1 << sew_bytes(sew)) - 1);

    addr_check: assert property (@(posedge clk) disable iff (!n_rst)
        (ld_req || st_req) |-> (lsu2mem_addr == exp_addr))
    else begin
        $display("ERROR lsu2mem_addr got %h expected %h",
                 $sampled(lsu2mem_addr), $sampled(exp_addr));
        fail_stop("address mismatch");
    end

    strobe_check: assert property (@(posedge clk) disable iff (!n_rst)
        st_req |-> (wr_strobe == exp_strb))
    else begin
        $display("ERROR wr_strobe got %h expected %h",
                 $sampled(wr_strobe), $sampled(exp_strb));
        fail_stop("store strobe mismatch");
    end

    vd_check: assert property (@(posedge clk) disable iff (!n_rst)
        is_loaded |-> (vd_data == exp_vd))
    else begin
        $display("ERROR vd_data got %h expected %h", $sampled(vd_data), $sampled(exp_vd));
        fail_stop("load image mismatch");
    end

    // Exactly vl request cycles, then one done pulse
    len_check: assert property (@(posedge clk) disable iff (!n_rst)
        $fell(ld_req || st_req) |-> (beat_k == int'(vl)))
    else begin
        $display("ERROR beat_k got %h expected %h", $sampled(beat_k), $sampled(vl));
        fail_stop("request length mismatch");
    end

    done_check: assert property (@(posedge clk) disable iff (!n_rst)
        ($fell(ld_req) |-> is_loaded) and ($fell(st_req) |-> is_stored))
    else fail_stop("done pulse missing after the request fell");

    pulse_check: assert property (@(posedge clk) disable iff (!n_rst)
        (is_loaded || is_stored) |=> !(is_loaded || is_stored || ld_req || st_req))
    else fail_stop("done pulse longer than one cycle or unit restarted");

    always @(posedge clk) begin
        if (UUT.u_chk.err_count != 0) fail_stop("a protocol assertion failed");
    end

    initial begin
        #(WATCH_CYCLES * 20);
        fail_stop("watchdog timeout, the test did not finish");
    end

    // One instruction; busy sends the other strobe during the request
    task automatic run_instr(input logic load, input addr_t base, input addr_t strd,
                             input logic unit, input logic idx, input sew_t w,
                             input vl_t n, input vreg_t v2, input vreg_t v3,
                             input logic busy);
        int sz;
        addr_t a;
        sz = sew_bytes(w);
        if (load) exp_vd = '0;
        for (int k = 0; k < int'(n); k++) begin
            a = elem_addr(k, base, strd, unit, idx, w, v2);
            for (int b = 0; b < sz; b++) begin
                if (load) exp_vd[(k*sz + b)*8 +: 8] = ref_mem[8'(a[7:0] + b)];
                else ref_mem[8'(a[7:0] + b)] = v3[(k*sz + b)*8 +: 8];
            end
        end
        rs1_data   = base;
        rs2_data   = strd;
        stride_sel = unit;
        index_str  = idx;
        sew        = w;
        vl         = n;
        vs2_data   = v2;
        vs3_data   = v3;
        ld_inst    = load;
        st_inst    = !load;
        @(negedge clk);
        ld_inst = 1'b0;
        st_inst = 1'b0;
        if (busy) begin
            ld_inst = !load;                // Must be ignored
            st_inst = load;
            @(negedge clk);
            ld_inst = 1'b0;
            st_inst = 1'b0;
        end
        while (!(is_loaded || is_stored)) @(negedge clk);
        if (!load) begin
            for (int i = 0; i < 256; i++) begin
                mem_check: assert (mem[i] === ref_mem[i]) else begin
                    $display("ERROR mem[%h] got %h expected %h", i, mem[i], ref_mem[i]);
                    fail_stop("memory contents mismatch after store");
                end
            end
        end
        @(negedge clk);                     // Idle gap
        @(negedge clk);
    endtask

    function automatic vreg_t rand_vreg();
        vreg_t v;
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            v[i*32 +: 32] = rng;
        end
        return v;
    endfunction

    initial begin
        ld_inst    = 0;
        st_inst    = 0;
        stride_sel = 0;
        index_str  = 0;
        rs1_data   = '0;
        rs2_data   = '0;
        sew        = SEW_8;
        vl         = 5'd1;
        vs2_data   = '0;
        vs3_data   = '0;
        exp_vd     = '0;
        for (int i = 0; i < 256; i++) begin
            rng = xorshift32(rng);
            mem[i]     = rng[7:0] ^ 8'(i);
            ref_mem[i] = rng[7:0] ^ 8'(i);
        end
        @(posedge n_rst);
        @(negedge clk);
        // Unit stride loads at each width, short ones leave zero slots
        run_instr(1, 32'h10, 0, 1, 0, SEW_8,  5'd16, '0, '0, 0);
        run_instr(1, 32'h31, 0, 1, 0, SEW_16, 5'd5,  '0, '0, 0);
        run_instr(1, 32'h62, 0, 1, 0, SEW_32, 5'd3,  '0, '0, 1);
        // Constant stride stores
        run_instr(0, 32'h80, 32'd6, 0, 0, SEW_16, 5'd5, '0, rand_vreg(), 1);
        run_instr(0, 32'hc1, 32'd3, 0, 0, SEW_8,  5'd4, '0, rand_vreg(), 0);
        // Indexed loads and store
        run_instr(1, 32'h20,  0, 0, 1, SEW_8,  5'd6, rand_vreg(), '0, 0);
        run_instr(1, 32'h7,   0, 0, 1, SEW_16, 5'd4, rand_vreg(), '0, 1);
        run_instr(0, 32'h100, 0, 0, 1, SEW_32, 5'd4, rand_vreg(), rand_vreg(), 0);
        if (UUT.u_chk.err_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_stop("a protocol assertion failed");
        end
    end

endmodule : vec_lsu_tb

`default_nettype wire
